// ==== hdl/filt_pkg.sv ====
// rx packet filter package with shared widths, rule bit positions, frame codes and length limits
package filt_pkg;

    // 802.11 header field types
    typedef logic [47:0] mac_addr_t;    // first octet on air sits in bits [7:0]
    typedef logic [1:0]  fc_type_t;
    typedef logic [3:0]  fc_subtype_t;
    typedef logic [1:0]  ds_bits_t;     // {to_ds, from_ds}

    // filter config word, bit order follows the mac80211 filter flags
    // bits 0, 2 and 3 are reserved
    typedef logic [13:0] filt_cfg_t;
    typedef logic [13:0] allow_vec_t;   // pass bits, same positions as filt_cfg_t
    typedef logic [8:0]  discard_vec_t; // discard bits for the low nine rules only

    // header walk states
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        WAIT_ADDR1 = 3'd1,
        WAIT_ADDR2 = 3'd2,
        WAIT_ADDR3 = 3'd3,
        ACTION     = 3'd4,
        ABNORMAL   = 3'd5
    } hdr_state_e;

    // rule bit positions in filt_cfg_t / allow_vec_t / discard_vec_t
    localparam int RULE_ALLMULTI    = 1;
    localparam int RULE_BCN_PRB     = 4;
    localparam int RULE_CONTROL     = 5;
    localparam int RULE_OTHER_BSS   = 6;
    localparam int RULE_PSPOLL      = 7;
    localparam int RULE_PROBE_REQ   = 8;
    localparam int RULE_UNICAST     = 9;   // allow only from here up
    localparam int RULE_BCAST_ONES  = 10;
    localparam int RULE_BCAST_ZEROS = 11;
    localparam int RULE_MY_BEACON   = 12;
    localparam int RULE_MONITOR     = 13;

    // frame control type codes
    localparam fc_type_t FT_MGMT = 2'd0;
    localparam fc_type_t FT_CTRL = 2'd1;

    // frame control subtype codes
    localparam fc_subtype_t ST_PROBE_REQ  = 4'd4;
    localparam fc_subtype_t ST_PROBE_RESP = 4'd5;
    localparam fc_subtype_t ST_BEACON     = 4'd8;
    localparam fc_subtype_t ST_PSPOLL     = 4'd10;  // control subtype

    // signalled length in bytes at which each address field ends
    localparam int LEN_ADDR1     = 14;
    localparam int LEN_ADDR2     = 20;
    localparam int LEN_ADDR3     = 26;
    localparam int LEN_SHORT_ALT = 32;  // also stops after addr1

    // multicast address prefixes, octets stored low byte first
    // 01:00:5e for ipv4 multicast
    localparam logic [23:0] MCAST_V4_PREFIX = 24'h5e0001;
    // 33:33 for ipv6 multicast
    localparam logic [15:0] MCAST_V6_PREFIX = 16'h3333;

endpackage

// ==== hdl/hdr_if.sv ====
// captured 802.11 header and its completion strobes, passed from the tracker to the filter stages
interface hdr_if;

    // one-cycle strobes, never high together
    logic                  hdr_done;      // header complete, fields stable
    logic                  hdr_abnormal;  // signalled length inconsistent

    // captured fields, held until the next frame's addr1
    filt_pkg::fc_type_t    fc_type;
    filt_pkg::fc_subtype_t fc_subtype;
    filt_pkg::mac_addr_t   addr1;

    // bssid picked by the ds bits
    filt_pkg::mac_addr_t   bssid;
    logic                  bssid_valid;   // low when the chosen address was not reached

    modport tracker (
        output hdr_done,
        output hdr_abnormal,
        output fc_type,
        output fc_subtype,
        output addr1,
        output bssid,
        output bssid_valid
    );

    modport sink (
        input hdr_done,
        input hdr_abnormal,
        input fc_type,
        input fc_subtype,
        input addr1,
        input bssid,
        input bssid_valid
    );

endinterface

// ==== hdl/rx_hdr_tracker.sv ====
// header walk FSM that follows the phy address strobes and captures frame control, addr1 and bssid
module rx_hdr_tracker #(
    parameter int LEN_W = 16
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  ht_unsupport,
    input  logic                  sig_valid,
    input  logic [LEN_W-1:0]      signal_len,
    input  filt_pkg::fc_type_t    fc_type,
    input  filt_pkg::fc_subtype_t fc_subtype,
    input  filt_pkg::ds_bits_t    fc_tofrom_ds,
    input  filt_pkg::mac_addr_t   addr1,
    input  logic                  addr1_valid,
    input  filt_pkg::mac_addr_t   addr2,
    input  logic                  addr2_valid,
    input  filt_pkg::mac_addr_t   addr3,
    input  logic                  addr3_valid,
    hdr_if.tracker                hdr
);

    filt_pkg::hdr_state_e state;
    filt_pkg::hdr_state_e state_nxt;

    logic [LEN_W-1:0] len_q;    // length latched with sig_valid

    logic accept_sig;
    logic take_a1;
    logic take_a2;
    logic take_a3;
    logic bssid_a1;
    logic bssid_a2;
    logic bssid_a3;

    // a new frame is only taken from idle
    assign accept_sig = (state == filt_pkg::IDLE) && sig_valid && !ht_unsupport;
    assign take_a1    = (state == filt_pkg::WAIT_ADDR1) && addr1_valid;
    assign take_a2    = (state == filt_pkg::WAIT_ADDR2) && addr2_valid;
    assign take_a3    = (state == filt_pkg::WAIT_ADDR3) && addr3_valid;

    // which address holds the bssid
    assign bssid_a1 = take_a1 && (fc_tofrom_ds == 2'b10);  // to-ds only
    assign bssid_a2 = take_a2 && (fc_tofrom_ds == 2'b01);  // from-ds only
    assign bssid_a3 = take_a3 && (fc_tofrom_ds == 2'b00);

    always_comb
    begin
        state_nxt = state;
        case (state)
            filt_pkg::IDLE:
                if (accept_sig)
                begin
                    if (signal_len < filt_pkg::LEN_ADDR1)
                        state_nxt = filt_pkg::ABNORMAL;
                    else
                        state_nxt = filt_pkg::WAIT_ADDR1;
                end
            filt_pkg::WAIT_ADDR1:
                if (take_a1)
                begin
                    if (len_q == filt_pkg::LEN_ADDR1 || len_q == filt_pkg::LEN_SHORT_ALT)
                        state_nxt = filt_pkg::ACTION;
                    else if (len_q >= filt_pkg::LEN_ADDR2)
                        state_nxt = filt_pkg::WAIT_ADDR2;
                    else
                        state_nxt = filt_pkg::ABNORMAL;    // 15..19
                end
            filt_pkg::WAIT_ADDR2:
                if (take_a2)
                begin
                    if (len_q == filt_pkg::LEN_ADDR2)
                        state_nxt = filt_pkg::ACTION;
                    else if (len_q >= filt_pkg::LEN_ADDR3)
                        state_nxt = filt_pkg::WAIT_ADDR3;
                    else
                        state_nxt = filt_pkg::ABNORMAL;    // 21..25
                end
            filt_pkg::WAIT_ADDR3:
                if (take_a3)
                    state_nxt = filt_pkg::ACTION;
            default:
                state_nxt = filt_pkg::IDLE;    // action and abnormal last one cycle
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state            <= filt_pkg::IDLE;
            hdr.hdr_done     <= 1'b0;
            hdr.hdr_abnormal <= 1'b0;
            hdr.bssid_valid  <= 1'b0;
        end
        else
        begin
            state            <= state_nxt;
            hdr.hdr_done     <= (state == filt_pkg::ACTION);
            hdr.hdr_abnormal <= (state == filt_pkg::ABNORMAL);
            if (accept_sig)
                hdr.bssid_valid <= 1'b0;
            else if (bssid_a1 || bssid_a2 || bssid_a3)
                hdr.bssid_valid <= 1'b1;
        end
    end

    // header payload
    always_ff @(posedge clk)
    begin
        if (accept_sig)
            len_q <= signal_len;
        if (take_a1)
        begin
            hdr.fc_type    <= fc_type;
            hdr.fc_subtype <= fc_subtype;
            hdr.addr1      <= addr1;
        end
        if (bssid_a1)
            hdr.bssid <= addr1;
        else if (bssid_a2)
            hdr.bssid <= addr2;
        else if (bssid_a3)
            hdr.bssid <= addr3;
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(hdr.hdr_done && hdr.hdr_abnormal));

    a_state_legal: assert property (@(posedge clk) disable iff (!rstn)
        state inside {filt_pkg::IDLE, filt_pkg::WAIT_ADDR1, filt_pkg::WAIT_ADDR2,
                      filt_pkg::WAIT_ADDR3, filt_pkg::ACTION, filt_pkg::ABNORMAL});

endmodule

// ==== hdl/frame_rule_eval.sv ====
// combinational evaluation of the mac80211 pass and discard rules for one captured header
module frame_rule_eval (
    hdr_if.sink                    hdr,
    input  filt_pkg::filt_cfg_t    filter_cfg,
    input  filt_pkg::mac_addr_t    self_mac_addr,
    input  filt_pkg::mac_addr_t    self_bssid,
    output filt_pkg::allow_vec_t   allow,
    output filt_pkg::discard_vec_t discard
);

    logic is_mgmt;
    logic is_ctrl;
    logic is_mcast;
    logic is_beacon;
    logic is_bcn_prb;
    logic is_ctrl_other;   // control but not ps-poll
    logic is_pspoll;
    logic is_probe_req;
    logic to_me;
    logic other_bss;
    logic my_bss;

    assign is_mgmt = (hdr.fc_type == filt_pkg::FT_MGMT);
    assign is_ctrl = (hdr.fc_type == filt_pkg::FT_CTRL);

    assign is_mcast = (hdr.addr1[23:0] == filt_pkg::MCAST_V4_PREFIX) ||
                      (hdr.addr1[15:0] == filt_pkg::MCAST_V6_PREFIX);

    assign is_beacon     = is_mgmt && (hdr.fc_subtype == filt_pkg::ST_BEACON);
    assign is_bcn_prb    = is_beacon ||
                           (is_mgmt && (hdr.fc_subtype == filt_pkg::ST_PROBE_RESP));
    assign is_pspoll     = is_ctrl && (hdr.fc_subtype == filt_pkg::ST_PSPOLL);
    assign is_ctrl_other = is_ctrl && !is_pspoll;
    assign is_probe_req  = is_mgmt && (hdr.fc_subtype == filt_pkg::ST_PROBE_REQ);

    assign to_me     = (hdr.addr1 == self_mac_addr);
    assign other_bss = hdr.bssid_valid && (hdr.bssid != self_bssid);
    assign my_bss    = hdr.bssid_valid && (hdr.bssid == self_bssid);

    always_comb
    begin
        allow   = '0;   // reserved bits stay low
        discard = '0;

        // rules with both a pass and a discard side
        allow[filt_pkg::RULE_ALLMULTI] = filter_cfg[filt_pkg::RULE_ALLMULTI] && is_mcast;
        discard[filt_pkg::RULE_ALLMULTI] = !filter_cfg[filt_pkg::RULE_ALLMULTI] && is_mcast;

        allow[filt_pkg::RULE_BCN_PRB] = filter_cfg[filt_pkg::RULE_BCN_PRB] && is_bcn_prb;
        // foreign beacons only
        discard[filt_pkg::RULE_BCN_PRB] = !filter_cfg[filt_pkg::RULE_BCN_PRB] &&
                                          is_bcn_prb && other_bss;

        allow[filt_pkg::RULE_CONTROL] = filter_cfg[filt_pkg::RULE_CONTROL] &&
                                        is_ctrl_other && to_me;
        discard[filt_pkg::RULE_CONTROL] = !filter_cfg[filt_pkg::RULE_CONTROL] &&
                                          is_ctrl_other;   // any address

        allow[filt_pkg::RULE_OTHER_BSS] = filter_cfg[filt_pkg::RULE_OTHER_BSS] && other_bss;
        discard[filt_pkg::RULE_OTHER_BSS] = !filter_cfg[filt_pkg::RULE_OTHER_BSS] &&
                                            other_bss;

        allow[filt_pkg::RULE_PSPOLL] = filter_cfg[filt_pkg::RULE_PSPOLL] && is_pspoll;
        discard[filt_pkg::RULE_PSPOLL] = !filter_cfg[filt_pkg::RULE_PSPOLL] && is_pspoll;

        allow[filt_pkg::RULE_PROBE_REQ] = filter_cfg[filt_pkg::RULE_PROBE_REQ] &&
                                          is_probe_req;
        discard[filt_pkg::RULE_PROBE_REQ] = !filter_cfg[filt_pkg::RULE_PROBE_REQ] &&
                                            is_probe_req;

        // pass-only rules
        allow[filt_pkg::RULE_UNICAST] = filter_cfg[filt_pkg::RULE_UNICAST] && to_me;
        allow[filt_pkg::RULE_BCAST_ONES] = filter_cfg[filt_pkg::RULE_BCAST_ONES] &&
                                           (hdr.addr1 == '1);
        allow[filt_pkg::RULE_BCAST_ZEROS] = filter_cfg[filt_pkg::RULE_BCAST_ZEROS] &&
                                            (hdr.addr1 == '0);
        allow[filt_pkg::RULE_MY_BEACON] = filter_cfg[filt_pkg::RULE_MY_BEACON] &&
                                          is_beacon && my_bss;
        allow[filt_pkg::RULE_MONITOR] = filter_cfg[filt_pkg::RULE_MONITOR];
    end

endmodule

// ==== hdl/rx_dma_gate.sv ====
// registers the per-frame rx dma block verdict and pulses its valid strobe
module rx_dma_gate (
    input  logic                   clk,
    input  logic                   rstn,
    hdr_if.sink                    hdr,
    input  filt_pkg::allow_vec_t   allow,
    input  filt_pkg::discard_vec_t discard,
    input  filt_pkg::filt_cfg_t    filter_cfg,
    input  filt_pkg::discard_vec_t discard_mask,
    output logic                   block,
    output logic                   block_valid
);

    filt_pkg::allow_vec_t   allow_sel;
    filt_pkg::discard_vec_t discard_sel;
    logic                   verdict_stb;
    logic                   block_nxt;

    assign verdict_stb = hdr.hdr_done || hdr.hdr_abnormal;

    // a bad length passes nothing and hits every discard rule
    assign allow_sel   = hdr.hdr_abnormal ? '0 : allow;
    assign discard_sel = hdr.hdr_abnormal ? '1 : discard;

    // monitor overrides everything
    assign block_nxt = !filter_cfg[filt_pkg::RULE_MONITOR] &&
                       ((allow_sel == '0) || ((discard_sel & discard_mask) != '0));

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            block       <= 1'b0;
            block_valid <= 1'b0;
        end
        else
        begin
            block_valid <= verdict_stb;
            if (verdict_stb)
                block <= block_nxt;   // held until the next verdict
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rstn)
        block_valid |=> !block_valid);

endmodule

// ==== hdl/pkt_filter_ctl.sv ====
// 802.11 rx packet filter top that decides per frame whether rx dma to the processor is blocked
module pkt_filter_ctl #(
    parameter int LEN_W = 16
) (
    input  logic                   clk,
    input  logic                   rstn,

    // configuration
    input  filt_pkg::filt_cfg_t    filter_cfg,
    input  filt_pkg::discard_vec_t discard_mask,
    input  filt_pkg::mac_addr_t    self_mac_addr,
    input  filt_pkg::mac_addr_t    self_bssid,

    // phy rx side
    input  logic                   ht_unsupport,
    input  logic                   sig_valid,
    input  logic [LEN_W-1:0]       signal_len,
    input  filt_pkg::fc_type_t     fc_type,
    input  filt_pkg::fc_subtype_t  fc_subtype,
    input  filt_pkg::ds_bits_t     fc_tofrom_ds,
    input  filt_pkg::mac_addr_t    addr1,
    input  logic                   addr1_valid,
    input  filt_pkg::mac_addr_t    addr2,
    input  logic                   addr2_valid,
    input  filt_pkg::mac_addr_t    addr3,
    input  logic                   addr3_valid,

    // verdict to rx dma
    output logic                   block,
    output logic                   block_valid
);

    filt_pkg::allow_vec_t   allow;
    filt_pkg::discard_vec_t discard;

    hdr_if u_hdr_if ();

    rx_hdr_tracker #(
        .LEN_W (LEN_W)
    ) u_rx_hdr_tracker (
        .clk          (clk),
        .rstn         (rstn),
        .ht_unsupport (ht_unsupport),
        .sig_valid    (sig_valid),
        .signal_len   (signal_len),
        .fc_type      (fc_type),
        .fc_subtype   (fc_subtype),
        .fc_tofrom_ds (fc_tofrom_ds),
        .addr1        (addr1),
        .addr1_valid  (addr1_valid),
        .addr2        (addr2),
        .addr2_valid  (addr2_valid),
        .addr3        (addr3),
        .addr3_valid  (addr3_valid),
        .hdr          (u_hdr_if.tracker)
    );

    frame_rule_eval u_frame_rule_eval (
        .hdr           (u_hdr_if.sink),
        .filter_cfg    (filter_cfg),
        .self_mac_addr (self_mac_addr),
        .self_bssid    (self_bssid),
        .allow         (allow),
        .discard       (discard)
    );

    rx_dma_gate u_rx_dma_gate (
        .clk          (clk),
        .rstn         (rstn),
        .hdr          (u_hdr_if.sink),
        .allow        (allow),
        .discard      (discard),
        .filter_cfg   (filter_cfg),
        .discard_mask (discard_mask),
        .block        (block),
        .block_valid  (block_valid)
    );

endmodule

// ==== tb/tb_pkt_filter.sv ====
// testbench for the rx packet filter that checks each verdict and its timing against a reference model
module tb_pkt_filter;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FRAMES = 246;    // all frames sent plus the gated starts
    localparam filt_pkg::mac_addr_t ME  = 48'h02a4_b3c2_d1e0;
    localparam filt_pkg::mac_addr_t BSS = 48'h5a6b_7c8d_9e00;

    logic                   clk;
    logic                   rstn;
    filt_pkg::filt_cfg_t    filter_cfg;
    filt_pkg::discard_vec_t discard_mask;
    filt_pkg::mac_addr_t    self_mac_addr;
    filt_pkg::mac_addr_t    self_bssid;
    logic                   ht_unsupport;
    logic                   sig_valid;
    logic [15:0]            signal_len;
    filt_pkg::fc_type_t     fc_type;
    filt_pkg::fc_subtype_t  fc_subtype;
    filt_pkg::ds_bits_t     fc_tofrom_ds;
    filt_pkg::mac_addr_t    addr1;
    filt_pkg::mac_addr_t    addr2;
    filt_pkg::mac_addr_t    addr3;
    logic                   addr1_valid;
    logic                   addr2_valid;
    logic                   addr3_valid;
    logic                   block;
    logic                   block_valid;

    int   seed = 32'h328a5993;
    int   errors = 0;
    int   checks = 0;
    int   cyc = 0;
    int   exp_cyc_q[$];     // cycle at which each verdict is due
    logic exp_blk_q[$];
    int   chk_cyc;
    logic chk_blk;
    logic held_blk = 1'b0;

    pkt_filter_ctl #(.LEN_W(16)) u_pkt_filter_ctl (
        .clk           (clk),
        .rstn          (rstn),
        .filter_cfg    (filter_cfg),
        .discard_mask  (discard_mask),
        .self_mac_addr (self_mac_addr),
        .self_bssid    (self_bssid),
        .ht_unsupport  (ht_unsupport),
        .sig_valid     (sig_valid),
        .signal_len    (signal_len),
        .fc_type       (fc_type),
        .fc_subtype    (fc_subtype),
        .fc_tofrom_ds  (fc_tofrom_ds),
        .addr1         (addr1),
        .addr1_valid   (addr1_valid),
        .addr2         (addr2),
        .addr2_valid   (addr2_valid),
        .addr3         (addr3),
        .addr3_valid   (addr3_valid),
        .block         (block),
        .block_valid   (block_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    // expected block for one frame straight from the filter rules
    function automatic logic ref_block(input int len, input filt_pkg::fc_type_t ftype,
            input filt_pkg::fc_subtype_t fsub, input filt_pkg::ds_bits_t ds,
            input filt_pkg::mac_addr_t a1, input filt_pkg::mac_addr_t a2,
            input filt_pkg::mac_addr_t a3, input filt_pkg::filt_cfg_t cfg,
            input filt_pkg::discard_vec_t mask, input filt_pkg::mac_addr_t me,
            input filt_pkg::mac_addr_t bss);
        logic [13:0]         alw;
        logic [8:0]          dis;
        int                  reach;
        logic                bss_ok;
        filt_pkg::mac_addr_t bssid;
        logic                mc;
        logic                bcn;
        logic                bcn_prb;
        logic                pspoll;
        logic                ctl;
        logic                preq;
        logic                other;

        if (cfg[13])
            return 1'b0;    // monitor
        if (len == 14 || len == 32)
            reach = 1;
        else if (len == 20)
            reach = 2;
        else if (len >= 26)
            reach = 3;
        else
            return 1'b1;    // inconsistent length so nothing passes
        bssid  = (ds == 2'b10) ? a1 : ((ds == 2'b01) ? a2 : a3);
        bss_ok = (ds == 2'b10) || (ds == 2'b01 && reach >= 2) || (ds == 2'b00 && reach == 3);
        mc      = (a1[7:0] == 8'h01 && a1[15:8] == 8'h00 && a1[23:16] == 8'h5e) ||
                  (a1[15:0] == 16'h3333);
        bcn     = (ftype == 2'd0) && (fsub == 4'd8);
        bcn_prb = bcn || ((ftype == 2'd0) && (fsub == 4'd5));
        pspoll  = (ftype == 2'd1) && (fsub == 4'd10);
        ctl     = (ftype == 2'd1) && !pspoll;
        preq    = (ftype == 2'd0) && (fsub == 4'd4);
        other   = bss_ok && (bssid != bss);
        alw = '0;
        dis = '0;
        alw[1]  = cfg[1] && mc;
        dis[1]  = !cfg[1] && mc;
        alw[4]  = cfg[4] && bcn_prb;
        dis[4]  = !cfg[4] && bcn_prb && other;
        alw[5]  = cfg[5] && ctl && (a1 == me);
        dis[5]  = !cfg[5] && ctl;
        alw[6]  = cfg[6] && other;
        dis[6]  = !cfg[6] && other;
        alw[7]  = cfg[7] && pspoll;
        dis[7]  = !cfg[7] && pspoll;
        alw[8]  = cfg[8] && preq;
        dis[8]  = !cfg[8] && preq;
        alw[9]  = cfg[9] && (a1 == me);
        alw[10] = cfg[10] && (a1 == 48'hffff_ffff_ffff);
        alw[11] = cfg[11] && (a1 == 48'h0);
        alw[12] = cfg[12] && bcn && bss_ok && (bssid == bss);
        return (alw == '0) || ((dis & mask) != '0);
    endfunction

    // address strobes the phy sends before the header ends or turns out bad
    function automatic int strobe_count(input int len);
        if (len < 14)
            return 0;
        if (len == 14 || len == 32 || len < 20)
            return 1;
        if (len < 26)
            return 2;
        return 3;
    endfunction

    // 0 own, 1 ones, 2 zeros, 3 ipv4 mcast, 4 ipv6 mcast, 5 own bssid, else random
    function automatic filt_pkg::mac_addr_t pick_addr(input int sel);
        logic [63:0] r;

        r = {$random(seed), $random(seed)};
        case (sel)
            0: return ME;
            1: return '1;
            2: return '0;
            3: return {r[23:0], 24'h5e0001};
            4: return {r[31:0], 16'h3333};
            5: return BSS;
            default: return r[47:0];
        endcase
    endfunction

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic send_frame(input int len, input filt_pkg::fc_type_t ftype,
            input filt_pkg::fc_subtype_t fsub, input filt_pkg::ds_bits_t ds,
            input filt_pkg::mac_addr_t a1, input filt_pkg::mac_addr_t a2,
            input filt_pkg::mac_addr_t a3);
        int last_cyc;

        @(negedge clk);
        signal_len   = 16'(len);
        fc_type      = ftype;
        fc_subtype   = fsub;
        fc_tofrom_ds = ds;
        addr1        = a1;
        addr2        = a2;
        addr3        = a3;
        sig_valid    = 1'b1;
        last_cyc     = cyc;
        @(negedge clk);
        sig_valid = 1'b0;
        for (int i = 1; i <= strobe_count(len); i++)
        begin
            repeat (2) @(negedge clk);
            addr1_valid = (i == 1);
            addr2_valid = (i == 2);
            addr3_valid = (i == 3);
            last_cyc    = cyc;
            @(negedge clk);
            {addr1_valid, addr2_valid, addr3_valid} = 3'b000;
        end
        exp_blk_q.push_back(ref_block(len, ftype, fsub, ds, a1, a2, a3, filter_cfg,
                                      discard_mask, ME, BSS));
        exp_cyc_q.push_back(last_cyc + 3);  // sampled edge plus two cycles
        while (exp_cyc_q.size() != 0)
            @(negedge clk);
    endtask

    // a start while ht_unsupport is high must leave the filter idle
    task automatic gated_start();
        @(negedge clk);
        ht_unsupport = 1'b1;
        signal_len   = 16'd14;
        sig_valid    = 1'b1;
        @(negedge clk);
        sig_valid   = 1'b0;
        addr1_valid = 1'b1;
        @(negedge clk);
        addr1_valid = 1'b0;
        repeat (6) @(negedge clk);
        ht_unsupport = 1'b0;
    endtask

    always @(negedge clk)
    begin
        if (rstn && block_valid)
        begin
            if (exp_cyc_q.size() == 0)
            begin
                errors++;
                $display("block_valid pulsed at cycle %0d with no verdict due", cyc);
            end
            else
            begin
                chk_cyc = exp_cyc_q.pop_front();
                chk_blk = exp_blk_q.pop_front();
                checks++;
                if (cyc != chk_cyc)
                begin
                    errors++;
                    $display("block_valid came at cycle %0d instead of cycle %0d", cyc, chk_cyc);
                end
                compare_bit("block", block, chk_blk);
            end
            held_blk = block;
        end
        else if (rstn)
        begin
            if (block !== held_blk)
            begin
                errors++;
                $display("block changed at cycle %0d without a block_valid pulse", cyc);
            end
            if (exp_cyc_q.size() != 0 && cyc >= exp_cyc_q[0])
            begin
                errors++;
                $display("block_valid missing at cycle %0d", cyc);
                chk_cyc = exp_cyc_q.pop_front();
                chk_blk = exp_blk_q.pop_front();
            end
        end
    end

    initial
    begin
        repeat (NUM_FRAMES * 40 + 200) @(posedge clk);
        $display("timeout after %0d cycles, the tests did not finish", cyc);
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        filt_pkg::filt_cfg_t    bcfg [4];
        filt_pkg::discard_vec_t bmask [4];
        filt_pkg::mac_addr_t    a [3];
        int                     mon_len [8];
        int                     abn_len [9];
        int                     rnd_len [9];
        logic [3:0]             sub_tab [4];
        int unsigned            r;

        bcfg     = '{14'h1000, 14'h0040, 14'h0010, 14'h1040};
        bmask    = '{9'h1ff, 9'h1ef, 9'h1ff, 9'h010};
        mon_len  = '{5, 14, 17, 20, 23, 26, 32, 40};
        abn_len  = '{0, 7, 13, 15, 17, 19, 21, 23, 25};
        rnd_len  = '{3, 14, 16, 20, 22, 26, 29, 32, 40};
        sub_tab  = '{4'd4, 4'd5, 4'd8, 4'd10};
        rstn = 1'b0;
        filter_cfg = '0;
        discard_mask = '0;
        self_mac_addr = ME;
        self_bssid = BSS;
        {ht_unsupport, sig_valid, addr1_valid, addr2_valid, addr3_valid} = 5'b0;
        signal_len = '0;
        {fc_type, fc_subtype, fc_tofrom_ds} = '0;
        {addr1, addr2, addr3} = '0;
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        compare_bit("block", block, 1'b0);
        compare_bit("block_valid", block_valid, 1'b0);
        repeat (5) @(negedge clk);

        // monitor lets every frame through including bad lengths
        for (int i = 0; i < 8; i++)
        begin
            filter_cfg   = 14'h2000 | 14'($random(seed));
            discard_mask = 9'($random(seed));
            send_frame(mon_len[i], 2'($random(seed)), 4'($random(seed)), 2'($random(seed)),
                       pick_addr(i % 7), pick_addr(6), pick_addr(5));
        end

        // unicast, all ones and all zeros over the four normal lengths
        discard_mask = '1;
        for (int c = 0; c < 3; c++)
            for (int k = 0; k < 3; k++)
                for (int l = 0; l < 4; l++)
                begin
                    filter_cfg = (c == 0) ? 14'h0200 : ((c == 1) ? 14'h0c00 : 14'h0000);
                    send_frame(14 + 6 * l, 2'd2, 4'd0, 2'b11, pick_addr(k), pick_addr(6),
                               pick_addr(6));
                end

        // multicast probe requests against the allmulti discard bit
        for (int k = 3; k < 5; k++)
        begin
            filter_cfg   = 14'h0100;
            discard_mask = 9'h002;
            send_frame(26, 2'd0, 4'd4, 2'b11, pick_addr(k), pick_addr(6), pick_addr(6));
            discard_mask = 9'h000;
            send_frame(26, 2'd0, 4'd4, 2'b11, pick_addr(k), pick_addr(6), pick_addr(6));
            filter_cfg   = 14'h0102;
            discard_mask = '1;
            send_frame(26, 2'd0, 4'd4, 2'b11, pick_addr(k), pick_addr(6), pick_addr(6));
        end

        // beacons with the own bssid in one address over every ds pair
        for (int d = 0; d < 4; d++)
            for (int p = 0; p < 3; p++)
                for (int c = 0; c < 4; c++)
                    for (int l = 0; l < 3; l++)
                    begin
                        filter_cfg   = bcfg[c];
                        discard_mask = bmask[c];
                        for (int j = 0; j < 3; j++)
                            a[j] = (j == p) ? BSS : pick_addr(6);
                        send_frame(14 + 6 * l, 2'd0, 4'd8, 2'(d), a[0], a[1], a[2]);
                    end

        // inconsistent lengths block even a frame for us
        filter_cfg   = 14'h0200;
        discard_mask = '0;
        foreach (abn_len[i])
            send_frame(abn_len[i], 2'd2, 4'd0, 2'b11, ME, pick_addr(6), pick_addr(6));

        repeat (3) gated_start();

        for (int i = 0; i < 40; i++)
        begin
            filter_cfg = 14'($random(seed)) & 14'h1fff;
            if (($random(seed) & 7) == 0)
                filter_cfg[13] = 1'b1;
            discard_mask = 9'($random(seed));
            r = $unsigned($random(seed));
            send_frame(rnd_len[r % 9], 2'(r >> 8),
                       ((r >> 12) % 5 == 4) ? 4'(r >> 16) : sub_tab[(r >> 12) % 5],
                       2'(r >> 20), pick_addr((r >> 22) % 8),
                       pick_addr(((r >> 25) & 1) ? 5 : 6), pick_addr(((r >> 26) & 1) ? 5 : 6));
        end

        repeat (4) @(negedge clk);
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== sim.f ====
hdl/filt_pkg.sv
hdl/hdr_if.sv
hdl/rx_hdr_tracker.sv
hdl/frame_rule_eval.sv
hdl/rx_dma_gate.sv
hdl/pkt_filter_ctl.sv
tb/tb_pkt_filter.sv

// ==== Bender.yml ====
package:
  name: pkt_filter_ctl

sources:
  - files:
      - hdl/filt_pkg.sv
      - hdl/hdr_if.sv
      - hdl/rx_hdr_tracker.sv
      - hdl/frame_rule_eval.sv
      - hdl/rx_dma_gate.sv
      - hdl/pkt_filter_ctl.sv
  - target: test
    files:
      - tb/tb_pkt_filter.sv
